//--- hw/rv_pkg.sv
// rv32i core package
// shared widths, opcodes, funct codes, enums and structs for the multicycle core
package rv_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction word
    typedef logic [4:0]  reg_addr_t; // register index

    localparam word_t RESET_PC = 32'h8000_0000;
    localparam int    NUM_REGS = 32;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011; // decoded for its immediate only

    // branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000; // add/sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl/sra by funct7 bit 5
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N  // no operands, retires as a no-op
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WAIT,
        EXEC
    } seq_state_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;     // sign extended
        inst_fmt_t  fmt;
        alu_op_t    alu_op;
    } decode_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      rd_we;
        reg_addr_t rd;
        word_t     rd_data;
        word_t     next_pc;
    } retire_t;

endpackage

//--- hw/reg_file.sv
// integer register file
// 32 x 32 bits, two combinational read ports, one write port strobed by commit
module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  logic              rd_we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_data,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // x0 is cleared here and the execute unit never asks to write it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && rd_we) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- hw/inst_decoder.sv
// instruction decoder
// field split, format lookup, sign extended immediate and alu op select
module inst_decoder (
    input  rv_pkg::word_t   inst,
    output rv_pkg::decode_t dec
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_pkg::inst_fmt_t  fmt;
    rv_pkg::word_t      imm;
    rv_pkg::alu_op_t    alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // loads, system and anything unknown fall to FMT_N
    always_comb begin
        case (opcode)
            rv_pkg::OP_REG:    fmt = rv_pkg::FMT_R;
            rv_pkg::OP_IMM:    fmt = rv_pkg::FMT_I;
            rv_pkg::OP_JALR:   fmt = rv_pkg::FMT_I;
            rv_pkg::OP_STORE:  fmt = rv_pkg::FMT_S;
            rv_pkg::OP_BRANCH: fmt = rv_pkg::FMT_B;
            rv_pkg::OP_LUI:    fmt = rv_pkg::FMT_U;
            rv_pkg::OP_AUIPC:  fmt = rv_pkg::FMT_U;
            rv_pkg::OP_JAL:    fmt = rv_pkg::FMT_J;
            default:           fmt = rv_pkg::FMT_N;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_pkg::FMT_I: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            rv_pkg::FMT_S: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_pkg::FMT_B: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::FMT_U: begin
                imm = {inst[31:12], 12'b0}; // upper immediate, low bits zero
            end
            rv_pkg::FMT_J: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // everything outside OP / OP-IMM adds, which covers pc+imm and rs1+imm
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OP_REG || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                rv_pkg::F3_ADD: begin
                    if (fmt == rv_pkg::FMT_R && funct7[5]) begin
                        alu_op = rv_pkg::ALU_SUB; // no subi in rv32i
                    end
                end
                rv_pkg::F3_SLL:  alu_op = rv_pkg::ALU_SLL;
                rv_pkg::F3_SLT:  alu_op = rv_pkg::ALU_SLT;
                rv_pkg::F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
                rv_pkg::F3_XOR:  alu_op = rv_pkg::ALU_XOR;
                rv_pkg::F3_SR:   alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                rv_pkg::F3_OR:   alu_op = rv_pkg::ALU_OR;
                rv_pkg::F3_AND:  alu_op = rv_pkg::ALU_AND;
                default:         alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm;
        dec.fmt    = fmt;
        dec.alu_op = alu_op;
    end

endmodule

//--- hw/exec_unit.sv
// execute unit
// operand select, alu, branch compare, writeback value and next pc
module exec_unit (
    input  rv_pkg::decode_t dec,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    output logic            rd_we,
    output rv_pkg::word_t   rd_data,
    output rv_pkg::word_t   next_pc
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t pc_plus4;
    logic [4:0]    shamt;
    logic          taken;     // branch condition
    logic          wb_en;     // instruction writes rd

    always_comb begin
        case (dec.fmt)
            rv_pkg::FMT_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            rv_pkg::FMT_I: begin
                alu_a = rs1_data; // op-imm and jalr
                alu_b = dec.imm;
            end
            rv_pkg::FMT_U: begin
                alu_a = (dec.opcode == rv_pkg::OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            rv_pkg::FMT_J, rv_pkg::FMT_B: begin
                alu_a = pc;        // jump / branch target
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  alu_result = alu_a + alu_b;
            rv_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            rv_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            rv_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // compare always on the register values, never the alu operands
    always_comb begin
        case (dec.funct3)
            rv_pkg::F3_BEQ:  taken = (rs1_data == rs2_data);
            rv_pkg::F3_BNE:  taken = (rs1_data != rs2_data);
            rv_pkg::F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_pkg::F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_pkg::F3_BLTU: taken = (rs1_data < rs2_data);
            rv_pkg::F3_BGEU: taken = (rs1_data >= rs2_data);
            default:         taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        wb_en   = 1'b0;
        rd_data = alu_result;
        next_pc = pc_plus4; // unsupported opcodes just step over
        case (dec.opcode)
            rv_pkg::OP_REG, rv_pkg::OP_IMM, rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: begin
                wb_en = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                wb_en   = 1'b1;
                rd_data = pc_plus4; // link
                next_pc = alu_result;
            end
            rv_pkg::OP_JALR: begin
                wb_en   = 1'b1;
                rd_data = pc_plus4;
                next_pc = {alu_result[31:1], 1'b0};
            end
            rv_pkg::OP_BRANCH: begin
                if (taken) begin
                    next_pc = alu_result;
                end
            end
            default: begin
                wb_en = 1'b0;
            end
        endcase
    end

    assign rd_we = wb_en && (dec.rd != '0); // keeps x0 at zero

endmodule

//--- hw/core_sequencer.sv
// core sequencer
// fetch / wait / exec control, owns the pc, the instruction register and the retire record
module core_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_valid,
    input  rv_pkg::word_t     inst_data,
    input  logic              rd_we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_data,
    input  rv_pkg::word_t     next_pc,
    output logic              fetch_req,
    output rv_pkg::word_t     fetch_addr,
    output rv_pkg::word_t     inst,
    output rv_pkg::word_t     pc,
    output logic              commit,
    output logic              retire_valid,
    output rv_pkg::retire_t   retire_info
);

    rv_pkg::seq_state_t state;
    rv_pkg::seq_state_t next_state;

    always_comb begin
        case (state)
            rv_pkg::IDLE:  next_state = rv_pkg::FETCH;
            rv_pkg::FETCH: next_state = rv_pkg::WAIT;
            rv_pkg::WAIT:  next_state = inst_valid ? rv_pkg::EXEC : rv_pkg::WAIT;
            rv_pkg::EXEC:  next_state = rv_pkg::FETCH;
            default:       next_state = rv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // pc only moves at the end of exec, so fetch_addr holds through the wait
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else if (state == rv_pkg::EXEC) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_pkg::WAIT && inst_valid) begin
            inst <= inst_data; // late valid pulses are ignored
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= (state == rv_pkg::EXEC);
        end
    end

    // retire record lines up with the next fetch
    always_ff @(posedge clk) begin
        if (state == rv_pkg::EXEC) begin
            retire_info.pc      <= pc;
            retire_info.inst    <= inst;
            retire_info.rd_we   <= rd_we;
            retire_info.rd      <= rd;
            retire_info.rd_data <= rd_data;
            retire_info.next_pc <= next_pc;
        end
    end

    assign fetch_req  = (state == rv_pkg::FETCH);
    assign fetch_addr = pc;
    assign commit     = (state == rv_pkg::EXEC); // regfile writes at the end of exec

endmodule

//--- hw/rv_core.sv
// rv32i multicycle core top
// sequencer, decoder, register file and execute unit, one instruction at a time
module rv_core (
    input  logic            clk,
    input  logic            reset,
    output logic            fetch_req,
    output rv_pkg::word_t   fetch_addr,
    input  logic            inst_valid,
    input  rv_pkg::word_t   inst_data,
    output logic            retire_valid,
    output rv_pkg::retire_t retire_info
);

    rv_pkg::word_t   inst;      // instruction register
    rv_pkg::word_t   pc;
    rv_pkg::decode_t dec;
    rv_pkg::word_t   rs1_data;
    rv_pkg::word_t   rs2_data;
    rv_pkg::word_t   rd_data;
    rv_pkg::word_t   next_pc;
    logic            rd_we;
    logic            commit;    // one cycle write strobe

    core_sequencer seq_i (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .rd_we       (rd_we),
        .rd          (dec.rd),
        .rd_data     (rd_data),
        .next_pc     (next_pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .inst        (inst),
        .pc          (pc),
        .commit      (commit),
        .retire_valid(retire_valid),
        .retire_info (retire_info)
    );

    inst_decoder dec_i (
        .inst(inst),
        .dec (dec)
    );

    reg_file rf_i (
        .clk     (clk),
        .reset   (reset),
        .commit  (commit),
        .rd_we   (rd_we),
        .rd      (dec.rd),
        .rd_data (rd_data),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    exec_unit exu_i (
        .dec     (dec),
        .pc      (pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .next_pc (next_pc)
    );

endmodule

//--- bench/rv_core_sva.sv
// protocol assertions for the rv32i core
// fetch pulse width, retire timing and quiet outputs in reset
module rv_core_sva (
    input logic clk,
    input logic reset,
    input logic fetch_req,
    input logic inst_valid,
    input logic retire_valid,
    input logic commit
);
    timeunit 1ns;
    timeprecision 1ps;

    fetch_single: assert property (@(posedge clk) disable iff (reset) fetch_req |=> !fetch_req)
        else $error("fetch_req high for two cycles in a row");

    // first reset cycle skipped, state is unknown before it
    reset_quiet: assert property (@(posedge clk) $past(reset) && reset |-> !fetch_req && !commit)
        else $error("fetch_req or commit high during reset");

    retire_after_valid: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> ##2 (retire_valid && fetch_req))
        else $error("retire_valid with fetch_req not two cycles after inst_valid");

    retire_source: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(inst_valid, 2))
        else $error("retire_valid without inst_valid two cycles before");

endmodule

bind rv_core rv_core_sva sva_i (
    .clk         (clk),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .inst_valid  (inst_valid),
    .retire_valid(retire_valid),
    .commit      (commit)
);

//--- bench/tb_rv_core.sv
// testbench for the rv32i multicycle core
// random instructions under variable fetch latency against an isa model
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTS     = 400;
    localparam int FETCH_TIMEOUT = 40;

    logic            clk;
    logic            reset;
    logic            fetch_req;
    rv_pkg::word_t   fetch_addr;
    logic            inst_valid;
    rv_pkg::word_t   inst_data;
    logic            retire_valid;
    rv_pkg::retire_t retire_info;

    rv_pkg::word_t model_regs [rv_pkg::NUM_REGS];
    rv_pkg::word_t model_pc;
    logic [31:0]   rng_state;
    int            mismatch_count;
    int            protocol_count;
    logic          timed_out;

    rv_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .retire_valid(retire_valid),
        .retire_info (retire_info)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic rv_pkg::word_t random_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [2:0]  hi;
        logic [11:0] imm12;
        logic [20:0] off_j;
        logic [12:0] off_b;
        logic [6:0]  opc;
        rv_pkg::word_t ins;
        r     = next_random();
        s     = next_random();
        f3    = s[14:12];
        hi    = {r[8] & r[9], r[6] & r[7], r[4] & r[5]}; // rs2, rs1, rd in x16..x31
        off_j = {{12{s[31]}}, s[30:24], 2'b00};   // +-512 bytes
        off_b = {{4{s[31]}}, s[30:24], 2'b00};
        opc   = (s[13:12] == 2'd0) ? 7'b0000011 : (s[13:12] == 2'd1) ? 7'b1110011 :
                (s[13:12] == 2'd2) ? 7'b0100011 : 7'b0001111;
        imm12 = s[31:20];
        if (f3 == 3'd1) imm12 = {7'b0, s[24:20]};
        if (f3 == 3'd5) imm12 = {1'b0, s[15], 5'b0, s[24:20]};
        // mostly x0..x15 so results feed later instructions
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                ins = {1'b0, s[15] & (f3 == 3'd0 || f3 == 3'd5), 5'b0, hi[2], s[11:8],
                       hi[1], s[7:4], f3, hi[0], s[3:0], rv_pkg::OP_REG};
            4'd5, 4'd6, 4'd7, 4'd8:
                ins = {imm12, hi[1], s[7:4], f3, hi[0], s[3:0], rv_pkg::OP_IMM};
            4'd9:  ins = {s[31:12], hi[0], s[3:0], rv_pkg::OP_LUI};
            4'd10: ins = {s[31:12], hi[0], s[3:0], rv_pkg::OP_AUIPC};
            4'd11: ins = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], hi[0], s[3:0],
                          rv_pkg::OP_JAL};
            4'd12: ins = {{4{s[31]}}, s[31:24], hi[1], s[7:4], 3'b000, hi[0], s[3:0],
                          rv_pkg::OP_JALR};   // odd offsets too
            4'd13, 4'd14: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = {2'b00, f3[0]}; // beq / bne
                ins = {off_b[12], off_b[10:5], hi[2], s[11:8], hi[1], s[7:4], f3,
                       off_b[4:1], off_b[11], rv_pkg::OP_BRANCH};
            end
            default: ins = {s[31:7], opc};    // load, system, store, fence
        endcase
        return ins;
    endfunction

    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
            input logic is_reg, input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::word_t r;
        case (f3)
            3'd0:    r = (is_reg && alt) ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // expected writeback and next pc from the isa rules
    task automatic predict(input rv_pkg::word_t pc, input rv_pkg::word_t ins,
            output logic we, output rv_pkg::word_t wdata, output rv_pkg::word_t npc);
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm_i;
        logic          cond;
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        we    = 1'b1;
        wdata = pc + 32'd4;   // link value
        npc   = pc + 32'd4;
        case (ins[6:0])
            rv_pkg::OP_REG:   wdata = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            rv_pkg::OP_IMM:   wdata = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
            rv_pkg::OP_LUI:   wdata = {ins[31:12], 12'b0};
            rv_pkg::OP_AUIPC: wdata = pc + {ins[31:12], 12'b0};
            rv_pkg::OP_JAL:   npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            rv_pkg::OP_JALR:  npc = (a + imm_i) & ~32'd1;
            rv_pkg::OP_BRANCH: begin
                we = 1'b0;
                case (ins[14:12])
                    rv_pkg::F3_BEQ:  cond = (a == b);
                    rv_pkg::F3_BNE:  cond = (a != b);
                    rv_pkg::F3_BLT:  cond = ($signed(a) < $signed(b));
                    rv_pkg::F3_BGE:  cond = ($signed(a) >= $signed(b));
                    rv_pkg::F3_BLTU: cond = (a < b);
                    rv_pkg::F3_BGEU: cond = (a >= b);
                    default:         cond = 1'b0;
                endcase
                if (cond) npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: we = 1'b0;
        endcase
        if (ins[11:7] == 5'd0) we = 1'b0;
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t expected,
            input rv_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;   // drive point once outputs have settled
    endtask

    initial begin
        rv_pkg::word_t ins;
        rv_pkg::word_t exp_data;
        rv_pkg::word_t exp_npc;
        logic          exp_we;
        logic [31:0]   r;
        int            waited;
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst_data      = '0;
        rng_state      = 32'h580b;
        mismatch_count = 0;
        protocol_count = 0;
        timed_out      = 1'b0;
        model_pc       = rv_pkg::RESET_PC;
        for (int i = 0; i < rv_pkg::NUM_REGS; i++) model_regs[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_INSTS && !timed_out; n++) begin
            waited = 0;
            while (!fetch_req && waited < FETCH_TIMEOUT) begin
                next_cycle();
                waited++;
            end
            if (!fetch_req) begin
                $display("timeout: no fetch_req within %0d cycles at %0t", FETCH_TIMEOUT, $time);
                timed_out = 1'b1;
            end else begin
                check_word("fetch_addr", model_pc, fetch_addr);
                ins = random_inst();
                predict(model_pc, ins, exp_we, exp_data, exp_npc);
                r = next_random();
                repeat (1 + int'(r[1:0])) begin   // 1 to 4 cycles of latency
                    next_cycle();
                    check_word("fetch_addr", model_pc, fetch_addr);
                end
                inst_valid = 1'b1;
                inst_data  = ins;
                next_cycle();
                inst_valid = 1'b0;
                inst_data  = next_random();   // junk outside the wait state
                assert (!retire_valid) else begin
                    $display("retire_valid only one cycle after inst_valid at %0t", $time);
                    protocol_count++;
                end
                next_cycle();
                assert (retire_valid && fetch_req) else begin
                    $display("no retire with fetch two cycles after inst_valid at %0t", $time);
                    protocol_count++;
                end
                check_word("retire_info.pc", model_pc, retire_info.pc);
                check_word("retire_info.inst", ins, retire_info.inst);
                check_word("retire_info.next_pc", exp_npc, retire_info.next_pc);
                check_word("retire_info.rd_we", {31'b0, exp_we}, {31'b0, retire_info.rd_we});
                check_word("retire_info.rd", {27'b0, ins[11:7]}, {27'b0, retire_info.rd});
                if (exp_we) begin
                    check_word("retire_info.rd_data", exp_data, retire_info.rd_data);
                    model_regs[ins[11:7]] = exp_data;
                end
                model_pc = exp_npc;
            end
        end
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatch_count, protocol_count, int'(timed_out));
        if (mismatch_count == 0 && protocol_count == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rv_core.f
hw/rv_pkg.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/exec_unit.sv
hw/core_sequencer.sv
hw/rv_core.sv
bench/rv_core_sva.sv
bench/tb_rv_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o tb_rv_core

output=$(./obj_dir/tb_rv_core) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
